/* ctrl_pkg.sv */
/*
  shared types for the trap and sequencing controller
  cause codes follow the machine mode mcause encoding, NMI uses code 31
  fast interrupt causes are 16 plus the line index, so at most 15 lines
*/
`default_nettype none

package ctrl_pkg;

  // data and address width
  parameter int unsigned XLEN = 32;

  // default number of fast interrupt lines
  parameter int unsigned NUM_FAST_IRQ = 15;

  ////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////

  // controller states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN,
    WAIT_SLEEP,
    SLEEP
  } ctrl_state_e;

  // fetch address select
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // trap vector select, only meaningful with PC_EXC
  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  ////////////////////////////////////////////////////////////
  // cause codes
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       irq;
    logic [4:0] code;
  } exc_cause_t;

  localparam exc_cause_t EXC_CAUSE_FETCH_FAULT = '{irq: 1'b0, code: 5'd1};
  localparam exc_cause_t EXC_CAUSE_ILLEGAL     = '{irq: 1'b0, code: 5'd2};
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT  = '{irq: 1'b0, code: 5'd3};
  localparam exc_cause_t EXC_CAUSE_LOAD_FAULT  = '{irq: 1'b0, code: 5'd5};
  localparam exc_cause_t EXC_CAUSE_STORE_FAULT = '{irq: 1'b0, code: 5'd7};
  localparam exc_cause_t EXC_CAUSE_ECALL_U     = '{irq: 1'b0, code: 5'd8};
  localparam exc_cause_t EXC_CAUSE_ECALL_M     = '{irq: 1'b0, code: 5'd11};
  localparam exc_cause_t IRQ_CAUSE_SOFTWARE    = '{irq: 1'b1, code: 5'd3};
  localparam exc_cause_t IRQ_CAUSE_TIMER       = '{irq: 1'b1, code: 5'd7};
  localparam exc_cause_t IRQ_CAUSE_EXTERNAL    = '{irq: 1'b1, code: 5'd11};
  localparam exc_cause_t IRQ_CAUSE_NMI         = '{irq: 1'b1, code: 5'd31};

endpackage

`default_nettype wire

/* exc_if.sv */
/*
  prioritised exception from the prioritiser to the FSM
  plain levels, cause and mtval only valid while exc_pending is high
*/
`default_nettype none

interface exc_if;
  import ctrl_pkg::*;

  logic             exc_pending;
  exc_cause_t       exc_cause;
  logic [XLEN-1:0]  exc_mtval;
  logic             special_req;
  logic             mret_req;
  logic             wfi_req;

  modport prioritiser (
    output exc_pending, exc_cause, exc_mtval, special_req, mret_req, wfi_req
  );

  modport fsm (
    input exc_pending, exc_cause, exc_mtval, special_req, mret_req, wfi_req
  );

endinterface

`default_nettype wire

/* irq_if.sv */
/*
  interrupt decision from the arbiter to the FSM
  nmi_mode runs back from the FSM to block nested interrupts
*/
`default_nettype none

interface irq_if;
  import ctrl_pkg::*;

  logic       handle_irq;
  exc_cause_t irq_cause;
  logic       is_nmi;
  logic       wake;
  logic       nmi_mode;

  modport arbiter (
    output handle_irq, irq_cause, is_nmi, wake,
    input  nmi_mode
  );

  modport fsm (
    input  handle_irq, irq_cause, is_nmi, wake,
    output nmi_mode
  );

endinterface

`default_nettype wire

/* exc_prioritiser.sv */
/*
  decode and load/store exception prioritiser
  the faulting instruction must stay in ID through FLUSH, since fetch fault,
  ECALL and EBREAK are read live there; load/store faults are single pulses
*/
`default_nettype none

module exc_prioritiser (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      instr_valid_i,
  input  logic                      illegal_insn_i,
  input  logic                      ecall_insn_i,
  input  logic                      ebrk_insn_i,
  input  logic                      mret_insn_i,
  input  logic                      wfi_insn_i,
  input  logic                      instr_fetch_err_i,
  input  logic [ctrl_pkg::XLEN-1:0] instr_i,
  input  logic [ctrl_pkg::XLEN-1:0] pc_id_i,
  input  logic                      load_err_i,
  input  logic                      store_err_i,
  input  logic [ctrl_pkg::XLEN-1:0] lsu_addr_last_i,
  input  ctrl_pkg::priv_lvl_e       priv_mode_i,
  input  ctrl_pkg::ctrl_state_e     ctrl_state_i,
  exc_if.prioritiser                exc
);
  import ctrl_pkg::*;

  logic fetch_err;
  logic ecall;
  logic ebrk;
  logic in_flush;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_q;
  logic store_err_q;

  // decoder flags carry no valid of their own
  assign fetch_err = instr_fetch_err_i & instr_valid_i;
  assign ecall     = ecall_insn_i & instr_valid_i;
  assign ebrk      = ebrk_insn_i & instr_valid_i;
  assign in_flush  = (ctrl_state_i == FLUSH);

  // cleared in FLUSH so a handled request does not linger
  assign illegal_d = illegal_insn_i & instr_valid_i & ~in_flush;
  assign exc_req_d = (fetch_err | illegal_d | ecall | ebrk) & ~in_flush;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_i & ~in_flush;
      store_err_q <= store_err_i & ~in_flush;
    end
  end

  ////////////////////////////////////////////////////////////
  // priority and cause
  ////////////////////////////////////////////////////////////

  // fetch fault > illegal > ECALL > EBREAK > store > load
  always_comb begin
    exc.exc_cause = '0;
    exc.exc_mtval = '0;
    if (fetch_err) begin
      exc.exc_cause = EXC_CAUSE_FETCH_FAULT;
      exc.exc_mtval = pc_id_i;
    end else if (illegal_q) begin
      exc.exc_cause = EXC_CAUSE_ILLEGAL;
      exc.exc_mtval = instr_i;
    end else if (ecall) begin
      exc.exc_cause = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_M : EXC_CAUSE_ECALL_U;
    end else if (ebrk) begin
      exc.exc_cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      exc.exc_cause = EXC_CAUSE_STORE_FAULT;
      exc.exc_mtval = lsu_addr_last_i;
    end else if (load_err_q) begin
      exc.exc_cause = EXC_CAUSE_LOAD_FAULT;
      exc.exc_mtval = lsu_addr_last_i;
    end
  end

  assign exc.exc_pending = exc_req_q | load_err_q | store_err_q;

  // lsu faults arrive without a valid instruction in ID
  assign exc.mret_req    = mret_insn_i & instr_valid_i;
  assign exc.wfi_req     = wfi_insn_i & instr_valid_i;
  assign exc.special_req = exc.mret_req | exc.wfi_req | exc_req_d | load_err_i | store_err_i;

endmodule

`default_nettype wire

/* irq_arbiter.sv */
/*
  interrupt masking and priority
  NumFastIrq may be 1 to 15; the cause is registered for use in IRQ_TAKEN
  mie only masks in M mode, NMI mode blocks everything including NMI
*/
`default_nettype none

module irq_arbiter #(
  parameter int unsigned NumFastIrq = ctrl_pkg::NUM_FAST_IRQ
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  csr_mstatus_mie_i,
  input  ctrl_pkg::priv_lvl_e   priv_mode_i,
  input  logic                  irq_software_i,
  input  logic                  irq_timer_i,
  input  logic                  irq_external_i,
  input  logic [NumFastIrq-1:0] irq_fast_i,
  input  logic                  irq_nm_i,
  irq_if.arbiter                irq
);
  import ctrl_pkg::*;

  logic       irq_enabled;
  logic       irq_pending;
  logic [3:0] fast_id;
  exc_cause_t cause_d, cause_q;
  logic       is_nmi_q;

  assign irq_enabled = csr_mstatus_mie_i | (priv_mode_i == PRIV_LVL_U);
  assign irq_pending = (|irq_fast_i) | irq_external_i | irq_software_i | irq_timer_i;

  assign irq.handle_irq = ~irq.nmi_mode & (irq_nm_i | (irq_pending & irq_enabled));

  // sleep ends on anything pending, mie does not matter here
  assign irq.wake = irq_nm_i | irq_pending;

  // lowest numbered fast line wins
  always_comb begin
    fast_id = '0;
    for (int i = int'(NumFastIrq) - 1; i >= 0; i--) begin
      if (irq_fast_i[i]) begin
        fast_id = 4'(i);
      end
    end
  end

  // NMI > fast > external > software > timer
  always_comb begin
    if (irq_nm_i) begin
      cause_d = IRQ_CAUSE_NMI;
    end else if (|irq_fast_i) begin
      // top code bit adds 16 to the line index
      cause_d = '{irq: 1'b1, code: {1'b1, fast_id}};
    end else if (irq_external_i) begin
      cause_d = IRQ_CAUSE_EXTERNAL;
    end else if (irq_software_i) begin
      cause_d = IRQ_CAUSE_SOFTWARE;
    end else begin
      cause_d = IRQ_CAUSE_TIMER;
    end
  end

  always_ff @(posedge clk_i) begin
    cause_q <= cause_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      is_nmi_q <= 1'b0;
    end else begin
      is_nmi_q <= irq_nm_i;
    end
  end

  assign irq.irq_cause = cause_q;
  assign irq.is_nmi    = is_nmi_q;

endmodule

`default_nettype wire

/* ctrl_fsm.sv */
/*
  controller FSM: boot, decode, flush, interrupt entry and sleep
  boot redirect starts one clock after reset release, two cycles of PC_BOOT
  no nested NMI; MRET leaves NMI mode
*/
`default_nettype none

module ctrl_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      instr_valid_i,
  input  logic                      stall_id_i,
  input  logic                      jump_set_i,
  output ctrl_pkg::ctrl_state_e     ctrl_state_o,
  exc_if.fsm                        exc,
  irq_if.fsm                        irq,
  output logic                      instr_req_o,
  output logic                      pc_set_o,
  output ctrl_pkg::pc_sel_e         pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e     exc_pc_mux_o,
  output ctrl_pkg::exc_cause_t      exc_cause_o,
  output logic [ctrl_pkg::XLEN-1:0] csr_mtval_o,
  output logic                      csr_save_if_o,
  output logic                      csr_save_id_o,
  output logic                      csr_save_cause_o,
  output logic                      csr_restore_mret_o,
  output logic                      nmi_mode_o,
  output logic                      ctrl_busy_o,
  output logic                      id_in_ready_o,
  output logic                      instr_valid_clear_o,
  output logic                      flush_id_o
);
  import ctrl_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        nmi_mode_q, nmi_mode_d;
  logic        boot_go_q;
  logic        halt_if;
  logic        retain_id;
  logic        flush_id;
  logic        irq_go;

  // ID must be empty and unstalled before an interrupt is taken
  assign irq_go = irq.handle_irq & ~stall_id_i & ~instr_valid_i;

  always_comb begin
    state_d            = state_q;
    nmi_mode_d         = nmi_mode_q;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    exc_cause_o        = '0;
    csr_mtval_o        = '0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    ctrl_busy_o        = 1'b1;
    halt_if            = 1'b0;
    retain_id          = 1'b0;
    flush_id           = 1'b0;

    unique case (state_q)
      RESET: begin
        // wait one clock after release before loading the boot address
        instr_req_o = 1'b0;
        pc_set_o    = boot_go_q;
        state_d     = boot_go_q ? BOOT_SET : RESET;
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end
      FIRST_FETCH: begin
        if (!stall_id_i && !irq.handle_irq) begin
          state_d = DECODE;
        end
        if (irq.handle_irq) begin
          halt_if = 1'b1;
          if (irq_go) begin
            state_d = IRQ_TAKEN;
          end
        end
      end
      DECODE: begin
        // mux set early, only used with pc_set_o
        pc_mux_o = PC_JUMP;
        if (exc.special_req) begin
          // keep the instruction in ID for FLUSH
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        if (jump_set_i) begin
          pc_set_o = 1'b1;
        end
        // pending interrupt holds IF until ID drains
        if (irq.handle_irq) begin
          halt_if = 1'b1;
          if (irq_go && !exc.special_req) begin
            state_d = IRQ_TAKEN;
          end
        end
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc.exc_pending) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = exc.exc_cause;
          csr_mtval_o      = exc.exc_mtval;
        end else if (exc.mret_req) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_restore_mret_o = 1'b1;
          nmi_mode_d         = 1'b0;
        end else if (exc.wfi_req) begin
          state_d = WAIT_SLEEP;
        end
      end
      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        // request may drop meanwhile, then just resume
        if (irq.handle_irq) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq.irq_cause;
          if (irq.is_nmi) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        if (irq.wake) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // stall control
  ////////////////////////////////////////////////////////////

  assign id_in_ready_o       = ~stall_id_i & ~halt_if & ~retain_id;
  // retain_id keeps the instruction unless it is flushed too
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o          = flush_id;

  assign nmi_mode_o   = nmi_mode_q;
  assign irq.nmi_mode = nmi_mode_q;
  assign ctrl_state_o = state_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
      boot_go_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
      boot_go_q  <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* ctrl_top.sv */
/*
  trap and sequencing controller top level, wiring only
  NumFastIrq from 1 to 15
*/
`default_nettype none

module ctrl_top #(
  parameter int unsigned NumFastIrq = ctrl_pkg::NUM_FAST_IRQ
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // decode stage
  input  logic                      instr_valid_i,
  input  logic                      illegal_insn_i,
  input  logic                      ecall_insn_i,
  input  logic                      ebrk_insn_i,
  input  logic                      mret_insn_i,
  input  logic                      wfi_insn_i,
  input  logic                      instr_fetch_err_i,
  input  logic [ctrl_pkg::XLEN-1:0] instr_i,
  input  logic [ctrl_pkg::XLEN-1:0] pc_id_i,
  input  logic                      stall_id_i,
  input  logic                      jump_set_i,
  // load/store unit
  input  logic                      load_err_i,
  input  logic                      store_err_i,
  input  logic [ctrl_pkg::XLEN-1:0] lsu_addr_last_i,
  // interrupts and CSR state
  input  ctrl_pkg::priv_lvl_e       priv_mode_i,
  input  logic                      csr_mstatus_mie_i,
  input  logic                      irq_software_i,
  input  logic                      irq_timer_i,
  input  logic                      irq_external_i,
  input  logic [NumFastIrq-1:0]     irq_fast_i,
  input  logic                      irq_nm_i,
  // fetch and CSR control
  output logic                      instr_req_o,
  output logic                      pc_set_o,
  output ctrl_pkg::pc_sel_e         pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e     exc_pc_mux_o,
  output ctrl_pkg::exc_cause_t      exc_cause_o,
  output logic [ctrl_pkg::XLEN-1:0] csr_mtval_o,
  output logic                      csr_save_if_o,
  output logic                      csr_save_id_o,
  output logic                      csr_save_cause_o,
  output logic                      csr_restore_mret_o,
  output logic                      nmi_mode_o,
  output logic                      ctrl_busy_o,
  output logic                      id_in_ready_o,
  output logic                      instr_valid_clear_o,
  output logic                      flush_id_o
);
  import ctrl_pkg::*;

  ctrl_state_e ctrl_state;

  exc_if exc_bus ();
  irq_if irq_bus ();

  exc_prioritiser u_exc_prio (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .illegal_insn_i    (illegal_insn_i),
    .ecall_insn_i      (ecall_insn_i),
    .ebrk_insn_i       (ebrk_insn_i),
    .mret_insn_i       (mret_insn_i),
    .wfi_insn_i        (wfi_insn_i),
    .instr_fetch_err_i (instr_fetch_err_i),
    .instr_i           (instr_i),
    .pc_id_i           (pc_id_i),
    .load_err_i        (load_err_i),
    .store_err_i       (store_err_i),
    .lsu_addr_last_i   (lsu_addr_last_i),
    .priv_mode_i       (priv_mode_i),
    .ctrl_state_i      (ctrl_state),
    .exc               (exc_bus.prioritiser)
  );

  irq_arbiter #(
    .NumFastIrq (NumFastIrq)
  ) u_irq_arb (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .csr_mstatus_mie_i (csr_mstatus_mie_i),
    .priv_mode_i       (priv_mode_i),
    .irq_software_i    (irq_software_i),
    .irq_timer_i       (irq_timer_i),
    .irq_external_i    (irq_external_i),
    .irq_fast_i        (irq_fast_i),
    .irq_nm_i          (irq_nm_i),
    .irq               (irq_bus.arbiter)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .stall_id_i          (stall_id_i),
    .jump_set_i          (jump_set_i),
    .ctrl_state_o        (ctrl_state),
    .exc                 (exc_bus.fsm),
    .irq                 (irq_bus.fsm),
    .instr_req_o         (instr_req_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .exc_cause_o         (exc_cause_o),
    .csr_mtval_o         (csr_mtval_o),
    .csr_save_if_o       (csr_save_if_o),
    .csr_save_id_o       (csr_save_id_o),
    .csr_save_cause_o    (csr_save_cause_o),
    .csr_restore_mret_o  (csr_restore_mret_o),
    .nmi_mode_o          (nmi_mode_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o)
  );

endmodule

`default_nettype wire

/* ctrl_props.sv */
/*
  output rules of the controller, bound into every ctrl_top
  all checks are disabled while rst_ni is low
*/
`default_nettype none

module ctrl_props (
  input logic clk_i,
  input logic rst_ni,
  input logic pc_set_o,
  input logic instr_req_o,
  input logic ctrl_busy_o,
  input logic csr_save_if_o,
  input logic csr_save_id_o,
  input logic csr_save_cause_o,
  input logic csr_restore_mret_o,
  input logic nmi_mode_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed checks so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // a cause is only saved together with a redirect
  cause_needs_redirect: assert property (
    @(posedge clk_i) disable iff (!rst_ni) csr_save_cause_o |-> pc_set_o
  ) else begin
    fail_cnt++;
    $error("csr_save_cause_o without pc_set_o");
  end

  // no fetch while asleep
  idle_no_fetch: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !ctrl_busy_o |-> !instr_req_o
  ) else begin
    fail_cnt++;
    $error("instr_req_o high while ctrl_busy_o is low");
  end

  save_if_id_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(csr_save_if_o && csr_save_id_o)
  ) else begin
    fail_cnt++;
    $error("csr_save_if_o and csr_save_id_o both high");
  end

  // only MRET leaves NMI mode
  nmi_exit_by_mret: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $fell(nmi_mode_o) |-> $past(csr_restore_mret_o)
  ) else begin
    fail_cnt++;
    $error("nmi_mode_o fell without csr_restore_mret_o");
  end

endmodule

bind ctrl_top ctrl_props props0 (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .pc_set_o           (pc_set_o),
  .instr_req_o        (instr_req_o),
  .ctrl_busy_o        (ctrl_busy_o),
  .csr_save_if_o      (csr_save_if_o),
  .csr_save_id_o      (csr_save_id_o),
  .csr_save_cause_o   (csr_save_cause_o),
  .csr_restore_mret_o (csr_restore_mret_o),
  .nmi_mode_o         (nmi_mode_o)
);

`default_nettype wire

/* tb_ctrl.sv */
/*
  table-driven testbench for ctrl_top, ID stage modelled by direct drive
  inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
  decode flags are held through FLUSH, lsu faults are single-cycle pulses
*/
`default_nettype none

module tb_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import ctrl_pkg::*;

  localparam int NUM_FAST = 15;
  localparam int TIMEOUT  = 20;
  // mtval source per row
  localparam int MT_Z   = 0;
  localparam int MT_PC  = 1;
  localparam int MT_INS = 2;
  localparam int MT_LSU = 3;

  typedef struct {
    logic [5:0]  exc;
    logic [3:0]  irq;
    logic [14:0] fast;
    logic        m_mode;
    logic        mie;
    logic        set;
    logic        c_irq;
    logic [4:0]  code;
    int          src;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic instr_valid_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, wfi_insn_i;
  logic instr_fetch_err_i, stall_id_i, jump_set_i, load_err_i, store_err_i;
  logic [XLEN-1:0] instr_i, pc_id_i, lsu_addr_last_i, csr_mtval_o;
  priv_lvl_e priv_mode_i;
  logic csr_mstatus_mie_i, irq_software_i, irq_timer_i, irq_external_i, irq_nm_i;
  logic [NUM_FAST-1:0] irq_fast_i;
  logic instr_req_o, pc_set_o, csr_save_if_o, csr_save_id_o, csr_save_cause_o;
  logic csr_restore_mret_o, nmi_mode_o, ctrl_busy_o, id_in_ready_o;
  logic instr_valid_clear_o, flush_id_o;
  pc_sel_e     pc_mux_o;
  exc_pc_sel_e exc_pc_mux_o;
  exc_cause_t  exc_cause_o;

  integer seed = 44889;
  int     errors = 0;
  int     tests = 0;
  int     failed = 0;
  row_t   rows[$];

  ctrl_top #(.NumFastIrq(NUM_FAST)) dut0 (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic idle_inputs();
    {instr_valid_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i} = '0;
    {mret_insn_i, wfi_insn_i, instr_fetch_err_i, stall_id_i, jump_set_i} = '0;
    {load_err_i, store_err_i, irq_software_i, irq_timer_i, irq_external_i, irq_nm_i} = '0;
    irq_fast_i        = '0;
    instr_i           = '0;
    pc_id_i           = '0;
    lsu_addr_last_i   = '0;
    priv_mode_i       = PRIV_LVL_M;
    csr_mstatus_mie_i = 1'b1;
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH @%0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: %0d error(s)", name, errors - err0);
    end
  endtask

  task automatic wait_for_pc_set(output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
      if (pc_set_o) begin
        seen = 1'b1;
      end else begin
        // lsu faults only last one cycle
        @(posedge clk_i);
        #1;
        load_err_i  = 1'b0;
        store_err_i = 1'b0;
      end
    end
  endtask

  task automatic wait_busy_low(output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
      seen = !ctrl_busy_o;
    end
  endtask

  function automatic row_t mk(input logic [5:0] exc, input logic [3:0] irq,
                              input logic [14:0] fast, input logic m_mode, input logic mie,
                              input logic set, input logic c_irq, input int code, input int src);
    row_t r;
    r.exc    = exc;
    r.irq    = irq;
    r.fast   = fast;
    r.m_mode = m_mode;
    r.mie    = mie;
    r.set    = set;
    r.c_irq  = c_irq;
    r.code   = 5'(code);
    r.src    = src;
    return r;
  endfunction

  task automatic build_rows();
    // exc {fetch,ill,ecall,ebrk,st,ld}, irq {nm,ext,sw,tmr}, fast, m, mie
    // then expected: redirect, cause irq bit, cause code, mtval source
    rows.push_back(mk(6'b100000, 4'h0, 15'h0000, 1, 1, 1, 0, 1, MT_PC));
    rows.push_back(mk(6'b111100, 4'h0, 15'h0000, 1, 1, 1, 0, 1, MT_PC));
    rows.push_back(mk(6'b011100, 4'h0, 15'h0000, 1, 1, 1, 0, 2, MT_INS));
    rows.push_back(mk(6'b001100, 4'h0, 15'h0000, 1, 1, 1, 0, 11, MT_Z));
    rows.push_back(mk(6'b001000, 4'h0, 15'h0000, 0, 1, 1, 0, 8, MT_Z));
    rows.push_back(mk(6'b000100, 4'h0, 15'h0000, 1, 1, 1, 0, 3, MT_Z));
    rows.push_back(mk(6'b000001, 4'h0, 15'h0000, 1, 1, 1, 0, 5, MT_LSU));
    rows.push_back(mk(6'b000010, 4'h0, 15'h0000, 1, 1, 1, 0, 7, MT_LSU));
    rows.push_back(mk(6'b000011, 4'h0, 15'h0000, 1, 1, 1, 0, 7, MT_LSU));
    rows.push_back(mk(6'b000110, 4'h0, 15'h0000, 1, 1, 1, 0, 3, MT_Z));
    // interrupts with ID idle
    rows.push_back(mk(6'b000000, 4'h1, 15'h0000, 1, 1, 1, 1, 7, MT_Z));
    rows.push_back(mk(6'b000000, 4'h3, 15'h0000, 1, 1, 1, 1, 3, MT_Z));
    rows.push_back(mk(6'b000000, 4'h7, 15'h0000, 1, 1, 1, 1, 11, MT_Z));
    rows.push_back(mk(6'b000000, 4'h4, 15'h0001, 1, 1, 1, 1, 16, MT_Z));
    rows.push_back(mk(6'b000000, 4'h0, 15'h0220, 1, 1, 1, 1, 21, MT_Z));
    rows.push_back(mk(6'b000000, 4'h0, 15'h4000, 1, 1, 1, 1, 30, MT_Z));
    // U mode ignores mie, M mode with mie low stays quiet
    rows.push_back(mk(6'b000000, 4'h1, 15'h0000, 0, 0, 1, 1, 7, MT_Z));
    rows.push_back(mk(6'b000000, 4'h4, 15'h0000, 1, 0, 0, 1, 11, MT_Z));
  endtask

  task automatic run_row(input int idx, input row_t r);
    logic [31:0] exp_mtval;
    bit          seen;
    int          err0;
    err0 = errors;
    @(posedge clk_i);
    #1;
    instr_i         = $random(seed);
    pc_id_i         = $random(seed);
    lsu_addr_last_i = $random(seed);
    {instr_fetch_err_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i} = r.exc[5:2];
    {store_err_i, load_err_i} = r.exc[1:0];
    {irq_nm_i, irq_external_i, irq_software_i, irq_timer_i} = r.irq;
    irq_fast_i        = r.fast;
    instr_valid_i     = |r.exc[5:2];
    priv_mode_i       = r.m_mode ? PRIV_LVL_M : PRIV_LVL_U;
    csr_mstatus_mie_i = r.mie;
    case (r.src)
      MT_PC:   exp_mtval = pc_id_i;
      MT_INS:  exp_mtval = instr_i;
      MT_LSU:  exp_mtval = lsu_addr_last_i;
      default: exp_mtval = '0;
    endcase
    wait_for_pc_set(seen);
    if (r.set) begin
      assert (seen) else begin
        $display("row %0d: no pc_set_o within %0d cycles", idx, TIMEOUT);
        errors++;
      end
      check_val("pc_mux_o", pc_mux_o, PC_EXC);
      check_val("exc_pc_mux_o", exc_pc_mux_o, r.c_irq ? EXC_PC_IRQ : EXC_PC_EXC);
      check_val("exc_cause_o", {26'b0, exc_cause_o}, {26'b0, r.c_irq, r.code});
      check_val("csr_mtval_o", csr_mtval_o, exp_mtval);
      check_val("csr_save_cause_o", csr_save_cause_o, 1);
      check_val("csr_save_if_o", csr_save_if_o, r.c_irq);
      check_val("csr_save_id_o", csr_save_id_o, !r.c_irq);
      // FLUSH holds and clears ID, interrupt entry leaves it open
      check_val("flush_id_o", flush_id_o, !r.c_irq);
      check_val("id_in_ready_o", id_in_ready_o, r.c_irq);
      check_val("instr_valid_clear_o", instr_valid_clear_o, 1);
    end else begin
      assert (!seen) else begin
        $display("MISMATCH @%0t: row %0d redirected while masked", $time, idx);
        errors++;
      end
    end
    @(posedge clk_i);
    #1;
    idle_inputs();
    report_test($sformatf("row %0d", idx), err0);
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int err0;
    bit seen;
    idle_inputs();
    rst_ni = 1'b0;
    build_rows();
    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    check_val("outputs in reset", {pc_set_o, csr_save_cause_o, csr_save_if_o, csr_save_id_o,
              csr_restore_mret_o, flush_id_o, nmi_mode_o}, 0);
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // boot: two cycles of PC_BOOT, fetch off in the first
    err0 = errors;
    wait_for_pc_set(seen);
    assert (seen) else begin
      $display("boot: no pc_set_o after reset release");
      errors++;
    end
    check_val("boot instr_req_o", instr_req_o, 0);
    check_val("boot pc_mux_o", pc_mux_o, PC_BOOT);
    @(negedge clk_i);
    check_val("boot pc_set_o", pc_set_o, 1);
    check_val("boot instr_req_o", instr_req_o, 1);
    check_val("boot pc_mux_o", pc_mux_o, PC_BOOT);
    @(negedge clk_i);
    check_val("pc_set_o after boot", pc_set_o, 0);
    report_test("boot", err0);

    // jump redirect in the same cycle, first cycle of DECODE
    err0 = errors;
    @(posedge clk_i);
    #1;
    jump_set_i = 1'b1;
    @(negedge clk_i);
    check_val("jump pc_set_o", pc_set_o, 1);
    check_val("jump pc_mux_o", pc_mux_o, PC_JUMP);
    @(posedge clk_i);
    #1;
    jump_set_i = 1'b0;
    report_test("jump", err0);

    foreach (rows[i]) begin
      run_row(i, rows[i]);
    end

    // NMI entry, nesting blocked, MRET leaves NMI mode
    err0 = errors;
    @(posedge clk_i);
    #1;
    irq_nm_i = 1'b1;
    wait_for_pc_set(seen);
    assert (seen) else begin
      $display("nmi: no pc_set_o within %0d cycles", TIMEOUT);
      errors++;
    end
    check_val("nmi exc_cause_o", {26'b0, exc_cause_o}, {26'b0, 1'b1, 5'd31});
    check_val("nmi exc_pc_mux_o", exc_pc_mux_o, EXC_PC_IRQ);
    @(posedge clk_i);
    #1;
    idle_inputs();
    @(negedge clk_i);
    check_val("nmi_mode_o after nmi", nmi_mode_o, 1);
    @(posedge clk_i);
    #1;
    irq_timer_i = 1'b1;
    wait_for_pc_set(seen);
    assert (!seen) else begin
      $display("MISMATCH @%0t: interrupt taken in NMI mode", $time);
      errors++;
    end
    @(posedge clk_i);
    #1;
    idle_inputs();
    instr_valid_i = 1'b1;
    mret_insn_i   = 1'b1;
    wait_for_pc_set(seen);
    assert (seen) else begin
      $display("mret: no pc_set_o within %0d cycles", TIMEOUT);
      errors++;
    end
    check_val("mret pc_mux_o", pc_mux_o, PC_ERET);
    check_val("csr_restore_mret_o", csr_restore_mret_o, 1);
    @(posedge clk_i);
    #1;
    idle_inputs();
    @(negedge clk_i);
    check_val("nmi_mode_o after mret", nmi_mode_o, 0);
    report_test("nmi and mret", err0);

    // WFI sleeps until an interrupt is pending, then takes it
    err0 = errors;
    @(posedge clk_i);
    #1;
    instr_valid_i = 1'b1;
    wfi_insn_i    = 1'b1;
    wait_busy_low(seen);
    assert (seen) else begin
      $display("wfi: ctrl_busy_o never went low");
      errors++;
    end
    @(posedge clk_i);
    #1;
    idle_inputs();
    repeat (4) begin
      @(negedge clk_i);
      check_val("ctrl_busy_o asleep", ctrl_busy_o, 0);
    end
    @(posedge clk_i);
    #1;
    irq_timer_i = 1'b1;
    @(negedge clk_i);
    check_val("ctrl_busy_o on wake", ctrl_busy_o, 1);
    wait_for_pc_set(seen);
    assert (seen) else begin
      $display("wfi: wake-up interrupt not taken within %0d cycles", TIMEOUT);
      errors++;
    end
    check_val("wake exc_cause_o", {26'b0, exc_cause_o}, {26'b0, 1'b1, 5'd7});
    @(posedge clk_i);
    #1;
    idle_inputs();
    report_test("wfi", err0);

    // pending interrupt waits while ID is stalled
    err0 = errors;
    @(posedge clk_i);
    #1;
    stall_id_i  = 1'b1;
    irq_timer_i = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_val("stalled pc_set_o", pc_set_o, 0);
      check_val("stalled id_in_ready_o", id_in_ready_o, 0);
      check_val("stalled instr_valid_clear_o", instr_valid_clear_o, 0);
    end
    @(posedge clk_i);
    #1;
    stall_id_i = 1'b0;
    wait_for_pc_set(seen);
    assert (seen) else begin
      $display("stall: interrupt not taken within %0d cycles after release", TIMEOUT);
      errors++;
    end
    check_val("stall exc_cause_o", {26'b0, exc_cause_o}, {26'b0, 1'b1, 5'd7});
    @(posedge clk_i);
    #1;
    idle_inputs();
    report_test("stall", err0);

    repeat (3) @(posedge clk_i);
    $display("%0d tests, %0d failed, %0d errors, %0d property failures",
             tests, failed, errors, dut0.props0.fail_cnt);
    if (errors == 0 && dut0.props0.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
ctrl_pkg.sv
exc_if.sv
irq_if.sv
exc_prioritiser.sv
irq_arbiter.sv
ctrl_fsm.sv
ctrl_top.sv
ctrl_props.sv
tb_ctrl.sv

/* Bender.yml */
package:
  name: ctrl_trap

sources:
  - ctrl_pkg.sv
  - exc_if.sv
  - irq_if.sv
  - exc_prioritiser.sv
  - irq_arbiter.sv
  - ctrl_fsm.sv
  - ctrl_top.sv
  - target: test
    files:
      - ctrl_props.sv
      - tb_ctrl.sv
